// ==== hw/br_pkg.sv ====
/*
	Branch resolution unit shared definitions
	Widths, Alpha branch opcodes and the records passed from
	issue through the operation buffer and resolver to the ROB
*/
package br_pkg;

	localparam int WORD_W      = 64;
	localparam int INST_W      = 32;
	localparam int ROB_IDX_W   = 5;
	localparam int DISP_W      = 21;                      // Branch format displacement field
	localparam int BUF_DEPTH   = 4;                       // Also the issue credit count
	localparam int BUF_PTR_W   = $clog2(BUF_DEPTH);
	localparam int CPL_CREDITS = 4;                       // ROB completion credits
	localparam int CPL_CNT_W   = $clog2(CPL_CREDITS + 1);

	typedef logic [WORD_W-1:0]    word_t;     // PCs, register values, targets
	typedef logic [INST_W-1:0]    inst_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [5:0]           opcode_t;   // inst[31:26]
	typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
	typedef logic [BUF_PTR_W:0]   buf_cnt_t;  // Holds 0 up to BUF_DEPTH
	typedef logic [CPL_CNT_W-1:0] cpl_cnt_t;

	localparam opcode_t    OP_JMP_CLASS = 6'h1A;  // JMP, JSR, RET, JSR_CO
	localparam opcode_t    OP_BR        = 6'h30;
	localparam opcode_t    OP_BSR       = 6'h34;
	localparam logic [2:0] OP_GRP_BR    = 3'b110; // Opcodes 0x30 to 0x37, always taken
	localparam logic [2:0] OP_GRP_CBR   = 3'b111; // Opcodes 0x38 to 0x3F, conditional

	// One issued branch operation
	typedef struct packed {
		word_t    npc;         // PC of the next sequential instruction
		word_t    opa;         // Register A value
		inst_t    inst;
		rob_idx_t rob_idx;
		logic     pred_taken;  // Front end prediction
		word_t    pred_target;
	} br_op_t;

	// One completion record toward the ROB
	typedef struct packed {
		rob_idx_t rob_idx;
		logic     taken;
		logic     mispredict;
		word_t    recovery_target; // Where fetch must restart
		word_t    br_pc;
	} br_cpl_t;

endpackage

// ==== hw/br_op_buf.sv ====
/*
	Branch operation buffer
	Circular FIFO of issued branches, read at the head by both
	evaluators, returns one issue credit for every entry popped
*/
`timescale 1ns/1ps

module br_op_buf
(
	input  logic           clk,
	input  logic           rst,
	input  logic           push_i,
	input  br_pkg::br_op_t push_op_i,
	input  logic           pop_i,
	output logic           head_valid_o,
	output br_pkg::br_op_t head_op_o,
	output logic           credit_o
);
	import br_pkg::*;

	br_op_t   mem [BUF_DEPTH]; // Payload storage
	buf_ptr_t wr_ptr;
	buf_ptr_t rd_ptr;
	buf_cnt_t count;
	logic     full;
	logic     do_push;
	logic     do_pop;

	// Next slot with wrap at the last entry
	function automatic buf_ptr_t ptr_inc(input buf_ptr_t p);
		if (p == buf_ptr_t'(BUF_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full         = (count == buf_cnt_t'(BUF_DEPTH));
	assign head_valid_o = (count != '0);
	assign head_op_o    = mem[rd_ptr];
	assign do_push      = push_i && !full;      // Push without a free slot is dropped
	assign do_pop       = pop_i && head_valid_o;

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_op_i;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
			credit_o <= do_pop;          // One credit back per pop
		end
	end

endmodule

// ==== hw/br_cond_eval.sv ====
/*
	Branch condition evaluator
	Tests the register A value for the Alpha conditional
	branches, func bits 1:0 pick the test and bit 2 inverts it
*/
`timescale 1ns/1ps

module br_cond_eval
(
	input  br_pkg::word_t opa_i,  // Register A value
	input  logic [2:0]    func_i, // inst[28:26]
	output logic          cond_o
);
	import br_pkg::*;

	logic sign;
	logic is_zero;
	logic raw;

	assign sign    = opa_i[WORD_W-1];
	assign is_zero = (opa_i == '0);

	always_comb
	begin
		case (func_i[1:0])
			2'b00:   raw = !opa_i[0];        // Low bit clear
			2'b01:   raw = is_zero;          // Equal to zero
			2'b10:   raw = sign;             // Negative
			default: raw = sign || is_zero;  // Negative or zero
		endcase
	end

	// Bit 2 gives the complementary branches
	assign cond_o = func_i[2] ? !raw : raw;

endmodule

// ==== hw/br_target_calc.sv ====
/*
	Branch target calculator
	Decodes the opcode into jump, unconditional or conditional
	class and forms the actual target of the operation
*/
`timescale 1ns/1ps

module br_target_calc
(
	input  br_pkg::word_t npc_i,
	input  br_pkg::word_t opa_i,
	input  br_pkg::inst_t inst_i,
	output br_pkg::word_t target_o,
	output logic          is_cond_o,
	output logic          is_branch_o
);
	import br_pkg::*;

	opcode_t opcode;
	word_t   disp;
	word_t   br_target;
	word_t   jmp_target;

	assign opcode = inst_i[31:26];

	// Sign extended displacement in longwords
	assign disp = {{(WORD_W - DISP_W - 2){inst_i[DISP_W-1]}}, inst_i[DISP_W-1:0], 2'b00};

	assign br_target  = npc_i + disp;
	assign jmp_target = {opa_i[WORD_W-1:2], 2'b00}; // Register target, aligned

	always_comb
	begin
		target_o    = npc_i; // Not a branch falls through
		is_cond_o   = 1'b0;
		is_branch_o = 1'b0;
		if (opcode == OP_JMP_CLASS)
		begin
			target_o    = jmp_target;
			is_branch_o = 1'b1;
		end
		else if (opcode[5:3] == OP_GRP_BR)
		begin
			// BR, BSR and the rest of the 0x30 group are always taken
			target_o    = br_target;
			is_branch_o = 1'b1;
		end
		else if (opcode[5:3] == OP_GRP_CBR)
		begin
			target_o    = br_target;
			is_cond_o   = 1'b1;
			is_branch_o = 1'b1;
		end
	end

endmodule

// ==== hw/br_resolve.sv ====
/*
	Branch resolver
	Merges condition and target with the prediction, registers
	the completion record on pop and tracks ROB completion credits
*/
`timescale 1ns/1ps

module br_resolve
(
	input  logic            clk,
	input  logic            rst,
	input  logic            head_valid_i,
	input  br_pkg::br_op_t  head_op_i,
	input  logic            cond_i,
	input  br_pkg::word_t   target_i,
	input  logic            is_cond_i,
	input  logic            is_branch_i,
	input  logic            rob_credit_i,
	output logic            pop_o,
	output logic            cpl_valid_o,
	output br_pkg::br_cpl_t cpl_o
);
	import br_pkg::*;

	cpl_cnt_t credit_cnt;  // Completion slots left in the ROB
	logic     taken;
	logic     tgt_miss;
	logic     mispredict;
	br_cpl_t  cpl_nxt;

	// Non branches never redirect
	assign taken = is_branch_i && (!is_cond_i || cond_i);

	assign tgt_miss   = (target_i != head_op_i.pred_target);
	assign mispredict = (taken != head_op_i.pred_taken) ||
		(taken && head_op_i.pred_taken && tgt_miss); // Right direction, wrong place

	always_comb
	begin
		cpl_nxt.rob_idx         = head_op_i.rob_idx;
		cpl_nxt.taken           = taken;
		cpl_nxt.mispredict      = mispredict;
		cpl_nxt.recovery_target = taken ? target_i : head_op_i.npc;
		cpl_nxt.br_pc           = head_op_i.npc;
	end

	// A credit arriving this cycle can be spent right away
	assign pop_o = head_valid_i && ((credit_cnt != '0) || rob_credit_i);

	always_ff @(posedge clk)
	begin
		if (pop_o)
			cpl_o <= cpl_nxt;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cpl_valid_o <= 1'b0;
			credit_cnt  <= cpl_cnt_t'(CPL_CREDITS);
		end
		else
		begin
			cpl_valid_o <= pop_o; // One cycle per completion
			case ({pop_o, rob_credit_i})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

endmodule

// ==== hw/br_unit_top.sv ====
/*
	Branch resolution unit
	Operation buffer feeding the condition and target
	evaluators, with the resolver reporting to the ROB
*/
`timescale 1ns/1ps

module br_unit_top
(
	input  logic            clk,
	input  logic            rst,
	input  logic            issue_valid_i,
	input  br_pkg::br_op_t  issue_op_i,
	output logic            issue_credit_o,
	input  logic            rob_credit_i,
	output logic            cpl_valid_o,
	output br_pkg::br_cpl_t cpl_o
);
	import br_pkg::*;

	br_op_t head_op;
	logic   head_valid;
	logic   pop;
	logic   cond;
	word_t  target;
	logic   is_cond;
	logic   is_branch;

	br_op_buf u_buf (
		.clk          (clk),
		.rst          (rst),
		.push_i       (issue_valid_i),
		.push_op_i    (issue_op_i),
		.pop_i        (pop),
		.head_valid_o (head_valid),
		.head_op_o    (head_op),
		.credit_o     (issue_credit_o)
	);

	br_cond_eval u_cond (
		.opa_i  (head_op.opa),
		.func_i (head_op.inst[28:26]), // Condition code of the branch
		.cond_o (cond)
	);

	br_target_calc u_target (
		.npc_i       (head_op.npc),
		.opa_i       (head_op.opa),
		.inst_i      (head_op.inst),
		.target_o    (target),
		.is_cond_o   (is_cond),
		.is_branch_o (is_branch)
	);

	br_resolve u_resolve (
		.clk          (clk),
		.rst          (rst),
		.head_valid_i (head_valid),
		.head_op_i    (head_op),
		.cond_i       (cond),
		.target_i     (target),
		.is_cond_i    (is_cond),
		.is_branch_i  (is_branch),
		.rob_credit_i (rob_credit_i),
		.pop_o        (pop),
		.cpl_valid_o  (cpl_valid_o),
		.cpl_o        (cpl_o)
	);

endmodule

// ==== sim/br_unit_ref.svh ====
/*
	Reference model of branch resolution
	Alpha condition set, target rules and mispredict rule,
	giving the completion record expected for one operation
*/
`ifndef BR_UNIT_REF_SVH
`define BR_UNIT_REF_SVH

// Alpha conditional test selected by inst[28:26]
function automatic logic cond_holds(input word_t opa, input logic [2:0] func);
	logic signed [63:0] v;
	v = opa;
	case (func)
		3'd0:    return opa[0] == 1'b0; // BLBC
		3'd1:    return v == 0;         // BEQ
		3'd2:    return v < 0;          // BLT
		3'd3:    return v <= 0;         // BLE
		3'd4:    return opa[0] == 1'b1; // BLBS
		3'd5:    return v != 0;         // BNE
		3'd6:    return v >= 0;         // BGE
		default: return v > 0;          // BGT
	endcase
endfunction

function automatic word_t resolved_target(input br_op_t op);
	logic [5:0]         opc;
	logic signed [63:0] offset;
	opc    = op.inst[31:26];
	offset = $signed(op.inst[20:0]); // Sign extended displacement
	if (opc == OP_JMP_CLASS)
		return op.opa & ~64'h3;
	if (opc >= 6'h30)
		return op.npc + word_t'(offset * 4);
	return op.npc;                   // Not a branch
endfunction

function automatic logic resolved_taken(input br_op_t op);
	logic [5:0] opc;
	opc = op.inst[31:26];
	if (opc == OP_JMP_CLASS || (opc >= 6'h30 && opc <= 6'h37))
		return 1'b1;
	if (opc >= 6'h38)
		return cond_holds(op.opa, op.inst[28:26]);
	return 1'b0;
endfunction

// Wrong direction, or taken both ways to different places
function automatic logic is_mispredicted(input br_op_t op);
	logic taken;
	taken = resolved_taken(op);
	if (taken != op.pred_taken)
		return 1'b1;
	return taken && (resolved_target(op) != op.pred_target);
endfunction

function automatic br_cpl_t expected_completion(input br_op_t op);
	br_cpl_t c;
	c.rob_idx         = op.rob_idx;
	c.taken           = resolved_taken(op);
	c.mispredict      = is_mispredicted(op);
	c.recovery_target = c.taken ? resolved_target(op) : op.npc;
	c.br_pc           = op.npc;
	return c;
endfunction

`endif

// ==== sim/br_unit_tb.sv ====
/*
	Branch resolution unit testbench
	Credit-aware issue of directed and random branches, a ROB
	model with delayed credit return, in-order completion check
*/
`timescale 1ns/1ps

module br_unit_tb;
	import br_pkg::*;

	`include "br_unit_ref.svh"

	localparam int TOTAL_OPS       = 362;                  // 1 + 40 + 8 + 5 + 8 + 300
	localparam int WATCHDOG_CYCLES = 40 * TOTAL_OPS + 200;

	logic     clk;
	logic     rst;
	logic     issue_valid_i;
	br_op_t   issue_op_i;
	logic     issue_credit_o;
	logic     rob_credit_i;
	logic     cpl_valid_o;
	br_cpl_t  cpl_o;

	integer   seed;
	int       cyc;
	int       issue_credits;  // Issue side credits held
	int       rob_balance;    // Completion credits the DUT holds
	int       issued_total;
	int       done_total;
	int       credit_pulses;
	int       hold_cpl;       // Completions while the ROB stalls
	logic     rob_hold;
	rob_idx_t next_rob_idx;
	br_cpl_t  exp_q [$];      // Expected records in issue order
	int       cyc_q [$];      // Issue cycle per record
	int       rob_due [$];    // Cycle each credit goes back
	word_t    cond_opa [5] = '{64'h0, 64'h35, 64'h42,
		64'hFFFF_FFFF_FFFF_FF00, 64'h0000_7000_0000_0010}; // Zero, odd, even, neg, pos

	br_unit_top uut (
		.clk            (clk),
		.rst            (rst),
		.issue_valid_i  (issue_valid_i),
		.issue_op_i     (issue_op_i),
		.issue_credit_o (issue_credit_o),
		.rob_credit_i   (rob_credit_i),
		.cpl_valid_o    (cpl_valid_o),
		.cpl_o          (cpl_o)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic show_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
		abort_run();
	endtask

	task automatic describe_error(input string what);
		$display("Error: %s", what);
		abort_run();
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	function automatic br_op_t build_op(input inst_t inst, input word_t npc, input word_t opa,
		input logic pred_taken, input word_t pred_target);
		br_op_t op;
		op             = '0;
		op.inst        = inst;
		op.npc         = npc;
		op.opa         = opa;
		op.pred_taken  = pred_taken;
		op.pred_target = pred_target;
		return op;
	endfunction

	task automatic make_random_op(output br_op_t op);
		logic [5:0] opc;
		case ($unsigned($random(seed)) % 6)
			0:       opc = OP_JMP_CLASS;
			1:       opc = {3'b110, 3'($random(seed))}; // 0x30 group
			2, 3:    opc = {3'b111, 3'($random(seed))}; // Conditional
			4:       opc = OP_BSR;
			default: opc = {3'b000, 3'($random(seed))}; // Not a branch
		endcase
		op = build_op({opc, 26'($random(seed))}, {$random(seed), $random(seed)} & ~64'h3,
			{$random(seed), $random(seed)}, 1'($random(seed)), {$random(seed), $random(seed)});
		if ($unsigned($random(seed)) % 4 == 0)
			op.opa = '0;
		if (op.pred_taken && 1'($random(seed)))
			op.pred_target = resolved_target(op); // Right target half the time
	endtask

	// Waits for a credit and drives one cycle of valid
	task automatic issue_op(input br_op_t op);
		while (issue_credits == 0)
			next_cycle();
		op.rob_idx    = next_rob_idx;
		next_rob_idx  = next_rob_idx + 1'b1;
		issue_valid_i = 1'b1;
		issue_op_i    = op;
		issue_credits--;
		exp_q.push_back(expected_completion(op));
		cyc_q.push_back(cyc);
		issued_total++;
		next_cycle();
		issue_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || rob_due.size() != 0)
			next_cycle();
	endtask

	task automatic check_completion();
		br_cpl_t exp;
		int      lat;
		assert (exp_q.size() != 0)
		else describe_error("completion with no operation outstanding");
		assert (rob_balance > 0)
		else describe_error("completion sent without a ROB credit");
		exp = exp_q.pop_front();
		lat = cyc - cyc_q.pop_front();
		assert (cpl_o.rob_idx == exp.rob_idx)
		else show_mismatch("cpl_o.rob_idx", cpl_o.rob_idx, exp.rob_idx);
		assert (cpl_o.taken == exp.taken)
		else show_mismatch("cpl_o.taken", cpl_o.taken, exp.taken);
		assert (cpl_o.mispredict == exp.mispredict)
		else show_mismatch("cpl_o.mispredict", cpl_o.mispredict, exp.mispredict);
		assert (cpl_o.recovery_target == exp.recovery_target)
		else show_mismatch("cpl_o.recovery_target", cpl_o.recovery_target, exp.recovery_target);
		assert (cpl_o.br_pc == exp.br_pc)
		else show_mismatch("cpl_o.br_pc", cpl_o.br_pc, exp.br_pc);
		// First op meets a free ROB and takes exactly two cycles
		assert (lat >= 2 && (done_total != 0 || lat == 2))
		else describe_error("completion latency out of range");
		done_total++;
		rob_balance--;
		if (rob_hold)
			hold_cpl++;
		rob_due.push_back(cyc + 1 + int'($unsigned($random(seed)) % 4));
	endtask

	// Outputs sampled mid cycle
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (issued_total == 0)
				assert (!cpl_valid_o && !issue_credit_o)
				else describe_error("DUT output active before any issue");
			if (issue_credit_o)
			begin
				issue_credits++;
				credit_pulses++;
			end
			if (cpl_valid_o)
				check_completion();
		end
	end

	// ROB model returning credits in completion order
	always @(posedge clk)
	begin
		#2;
		rob_credit_i = 1'b0;
		if (!rst && !rob_hold && rob_due.size() != 0 && rob_due[0] <= cyc)
		begin
			void'(rob_due.pop_front());
			rob_credit_i = 1'b1;
			rob_balance++;
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired: the operations did not all complete in time");
		abort_run();
	end

	initial
	begin
		br_op_t op;
		int     base;
		seed          = 32'h7413_f268;
		clk           = 1'b0;
		rst           = 1'b1;
		issue_valid_i = 1'b0;
		issue_op_i    = '0;
		rob_credit_i  = 1'b0;
		cyc           = 0;
		issue_credits = BUF_DEPTH;
		rob_balance   = CPL_CREDITS;
		issued_total  = 0;
		done_total    = 0;
		credit_pulses = 0;
		hold_cpl      = 0;
		rob_hold      = 1'b0;
		next_rob_idx  = '0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		repeat (3) next_cycle(); // Outputs must stay quiet

		issue_op(build_op({OP_BR, 5'd26, 21'h10}, 64'h800, 64'h0, 1'b1, 64'h840));
		wait_drain();

		for (int f = 0; f < 8; f++)
			for (int k = 0; k < 5; k++)
				issue_op(build_op({3'b111, 3'(f), 5'd3, 21'h40}, 64'h1000 + 64'(k * 8),
					cond_opa[k], 1'(k), 64'h1100));

		// Jump class, BR/BSR, negative displacements, fall through
		issue_op(build_op({OP_JMP_CLASS, 26'h0}, 64'h2000, 64'h4000_1237, 1'b1, 64'h0));
		issue_op(build_op({OP_JMP_CLASS, 26'h0}, 64'h2004, 64'hFFFF_FFFF_8000_0002, 1'b0, 64'h0));
		issue_op(build_op({OP_BR, 5'd0, 21'h000100}, 64'h2008, 64'h0, 1'b1, 64'h2408));
		issue_op(build_op({OP_BSR, 5'd26, 21'h1FFFF0}, 64'h200C, 64'h0, 1'b0, 64'h0));
		issue_op(build_op({OP_BR, 5'd0, 21'h100000}, 64'h2010, 64'h0, 1'b1, 64'h0));
		issue_op(build_op({6'h33, 5'd0, 21'h1FFFFF}, 64'h2014, 64'h0, 1'b0, 64'h0));
		issue_op(build_op({6'h39, 5'd1, 21'h1FFF00}, 64'h2018, 64'h7, 1'b1, 64'h0));
		issue_op(build_op({6'h10, 26'h123}, 64'h201C, 64'h5, 1'b1, 64'h2020));

		// Mispredict cases
		issue_op(build_op({OP_BR, 5'd0, 21'h8}, 64'h3000, 64'h0, 1'b0, 64'h3020));
		op = build_op({OP_BR, 5'd0, 21'h8}, 64'h3000, 64'h0, 1'b1, 64'h0);
		op.pred_target = resolved_target(op);
		issue_op(op);
		issue_op(build_op({6'h39, 5'd1, 21'h8}, 64'h3004, 64'h1, 1'b0, 64'h0));
		issue_op(build_op({6'h39, 5'd1, 21'h8}, 64'h3008, 64'h1, 1'b1, 64'h3028));
		issue_op(build_op({OP_BR, 5'd0, 21'h8}, 64'h300C, 64'h0, 1'b1, 64'h3024));

		// ROB back pressure until the buffer fills
		wait_drain();
		rob_hold = 1'b1;
		hold_cpl = 0;
		base     = issued_total;
		repeat (30)
		begin
			if (issue_credits > 0)
			begin
				make_random_op(op);
				issue_op(op);
			end
			else
				next_cycle();
		end
		assert (hold_cpl == CPL_CREDITS)
		else describe_error("completion count under ROB stall is wrong");
		assert (issued_total - base == BUF_DEPTH + CPL_CREDITS)
		else describe_error("issue credits did not stop once the buffer filled");
		rob_hold = 1'b0;
		wait_drain();

		repeat (300)
		begin
			make_random_op(op);
			issue_op(op);
		end
		wait_drain();
		repeat (3) next_cycle();

		if (credit_pulses != issued_total)
			describe_error("issue credit pulses differ from the issued count");
		else if (done_total != issued_total)
			describe_error("completion count differs from the issued count");
		else
		begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
+incdir+sim
hw/br_pkg.sv
hw/br_op_buf.sv
hw/br_cond_eval.sv
hw/br_target_calc.sv
hw/br_resolve.sv
hw/br_unit_top.sv
sim/br_unit_tb.sv
